// ==== design/mavg_consts.svh ====
//--------------------------------------------------------------------------
// Constants for the moving-average block: settings addresses, data
// widths, readback filler and divider latency
//--------------------------------------------------------------------------
`ifndef MAVG_CONSTS_SVH
`define MAVG_CONSTS_SVH

// Settings bus addresses
`define MAVG_SR_SUM_LEN 8'd192
`define MAVG_SR_DIVISOR 8'd193

// Width of one I or Q part
`define MAVG_SAMPLE_W 16

// Width of a running sum and of the divisor
`define MAVG_SUM_W 24

// History depth is 2**8, so window lengths up to 255
`define MAVG_MAX_LEN_LOG2 8

// Divider start to done, in ce_clk cycles
`define MAVG_DIV_CYCLES 26

// Returned for readback addresses with no register
`define MAVG_RB_FILLER 32'h0BADC0DE

`endif

// ==== design/mavg_cfg_pkg.sv ====
//--------------------------------------------------------------------------
// Settings bus types and the two views of the settings data word
//--------------------------------------------------------------------------
`default_nettype none

`include "mavg_consts.svh"

package mavg_cfg_pkg;

  // Data word as seen by the window length register
  typedef struct packed {
    logic [31-`MAVG_MAX_LEN_LOG2:0] rsvd;
    logic [`MAVG_MAX_LEN_LOG2-1:0]  sum_len;
  } len_view_t;

  // Data word as seen by the divisor register
  typedef struct packed {
    logic [31-`MAVG_SUM_W:0] rsvd;
    logic [`MAVG_SUM_W-1:0]  divisor;
  } div_view_t;

  // One 32-bit word, decoded by address
  typedef union packed {
    len_view_t len;
    div_view_t div;
  } set_word_u;

  typedef struct packed {
    logic      stb;
    logic [7:0] addr;
    set_word_u data;
  } set_bus_t;

endpackage

`default_nettype wire

// ==== design/mavg_data_pkg.sv ====
//--------------------------------------------------------------------------
// Sample, running sum and divider request/response types
//--------------------------------------------------------------------------
`default_nettype none

`include "mavg_consts.svh"

package mavg_data_pkg;

  // Complex baseband sample, I in the upper half
  typedef struct packed {
    logic signed [`MAVG_SAMPLE_W-1:0] i;
    logic signed [`MAVG_SAMPLE_W-1:0] q;
  } iq_sample_t;

  typedef logic signed [`MAVG_SUM_W-1:0] sum_t;

  // Operands are sampled in the start cycle only
  typedef struct packed {
    logic                   start;
    sum_t                   dividend;
    logic [`MAVG_SUM_W-1:0] divisor;
  } div_req_t;

  // Quotient is valid in the done cycle only
  typedef struct packed {
    logic                             done;
    logic signed [`MAVG_SAMPLE_W-1:0] quotient;
  } div_rsp_t;

endpackage

`default_nettype wire

// ==== design/mavg_settings.sv ====
//--------------------------------------------------------------------------
// Window length and divisor registers, clear pulse, readback mux
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mavg_consts.svh"

module mavg_settings
  import mavg_cfg_pkg::*;
(
  input  wire logic                           ce_clk,
  input  wire logic                           i_arst_n,
  input  wire set_bus_t                       i_set,
  input  wire logic [7:0]                     i_rb_addr,
  output logic [31:0]                         o_rb_data,
  output logic [`MAVG_MAX_LEN_LOG2-1:0]       o_sum_len,
  output logic [`MAVG_SUM_W-1:0]              o_divisor,
  output logic                                o_len_clear
);

  logic                          len_wr;
  logic                          div_wr;
  logic [`MAVG_MAX_LEN_LOG2-1:0] sum_len_r;
  logic [`MAVG_SUM_W-1:0]        divisor_r;
  logic                          len_clear_r;

  assign len_wr = i_set.stb && (i_set.addr == `MAVG_SR_SUM_LEN);
  assign div_wr = i_set.stb && (i_set.addr == `MAVG_SR_DIVISOR);

  // New length and the clear pulse show up in the same cycle
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sum_len_r   <= `MAVG_MAX_LEN_LOG2'(1);
      divisor_r   <= `MAVG_SUM_W'(1);
      len_clear_r <= 1'b0;
    end else begin
      len_clear_r <= len_wr;
      if (len_wr) begin
        sum_len_r <= i_set.data.len.sum_len;
      end
      if (div_wr) begin
        divisor_r <= i_set.data.div.divisor;
      end
    end
  end

  always_comb begin
    case (i_rb_addr)
      8'd0:    o_rb_data = {{(32-`MAVG_MAX_LEN_LOG2){1'b0}}, sum_len_r};
      8'd1:    o_rb_data = {{(32-`MAVG_SUM_W){1'b0}}, divisor_r};
      default: o_rb_data = `MAVG_RB_FILLER;
    endcase
  end

  assign o_sum_len   = sum_len_r;
  assign o_divisor   = divisor_r;
  assign o_len_clear = len_clear_r;

  // A zero window would never fill
  a_len_nonzero: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    len_clear_r |-> (sum_len_r != '0))
    else $error("window length written as 0");

endmodule

`default_nettype wire

// ==== design/moving_sum.sv ====
//--------------------------------------------------------------------------
// Windowed running sum of one signed sample stream
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mavg_consts.svh"

module moving_sum
  import mavg_data_pkg::*;
(
  input  wire logic                              ce_clk,
  input  wire logic                              i_arst_n,
  input  wire logic                              i_clear,
  input  wire logic [`MAVG_MAX_LEN_LOG2-1:0]     i_len,
  input  wire logic                              i_stb,
  input  wire logic signed [`MAVG_SAMPLE_W-1:0]  i_data,
  output logic                                   o_stb,
  output sum_t                                   o_sum
);

  localparam int LW    = `MAVG_MAX_LEN_LOG2;
  localparam int DEPTH = 1 << LW;

  logic signed [`MAVG_SAMPLE_W-1:0] hist_mem [DEPTH];

  logic [LW-1:0] wr_ptr;
  logic [LW-1:0] rd_ptr;
  logic [LW-1:0] fill_cnt;
  logic          full;
  logic          stb_r;
  sum_t          sum_r;
  sum_t          add_val;
  sum_t          sub_val;
  sum_t          sum_nxt;

  // Oldest sample still inside the window
  assign rd_ptr = wr_ptr - i_len;
  assign full   = (fill_cnt == i_len);

  always_comb begin
    add_val = sum_t'(i_data);
    sub_val = full ? sum_t'(hist_mem[rd_ptr]) : '0;
    // After a clear the new sample starts a fresh window
    sum_nxt = i_clear ? add_val : sum_r + add_val - sub_val;
  end

  always_ff @(posedge ce_clk) begin
    if (i_stb) begin
      hist_mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      stb_r    <= 1'b0;
      wr_ptr   <= '0;
      fill_cnt <= '0;
      sum_r    <= '0;
    end else begin
      stb_r <= i_stb;
      if (i_stb) begin
        wr_ptr <= wr_ptr + 1'b1;
        sum_r  <= sum_nxt;
        if (i_clear) begin
          fill_cnt <= LW'(1);
        end else if (!full) begin
          fill_cnt <= fill_cnt + 1'b1;
        end
      end else if (i_clear) begin
        sum_r    <= '0;
        fill_cnt <= '0;
      end
    end
  end

  assign o_stb = stb_r;
  assign o_sum = sum_r;

  // Length can only shrink together with a clear
  a_fill_in_window: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    !i_clear |-> (fill_cnt <= i_len))
    else $error("fill count %0d above window length %0d", fill_cnt, i_len);

endmodule

`default_nettype wire

// ==== design/divide_int24.sv ====
//--------------------------------------------------------------------------
// Sequential signed 24 by 24 restoring divider, fixed latency
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mavg_consts.svh"

module divide_int24
  import mavg_data_pkg::*;
(
  input  wire logic     ce_clk,
  input  wire logic     i_arst_n,
  input  wire div_req_t i_req,
  output div_rsp_t      o_rsp
);

  localparam int W     = `MAVG_SUM_W;
  localparam int STEPS = W;
  localparam int CW    = $clog2(STEPS + 1);

  logic                             busy;
  logic                             take;
  logic                             last_step;
  logic [CW-1:0]                    step_cnt;
  logic                             done_r;
  logic                             neg;
  logic [W-1:0]                     dvs_mag;
  logic [W-1:0]                     quo;
  logic [W-1:0]                     rem;
  logic [W:0]                       rem_sh;
  logic [W:0]                       trial;
  logic                             fits;
  logic signed [W-1:0]              quo_signed;
  logic signed [`MAVG_SAMPLE_W-1:0] quot_r;

  assign take      = i_req.start && !busy;
  assign last_step = (step_cnt == CW'(STEPS));

  // One restoring step: shift in the next dividend bit, try to subtract
  always_comb begin
    rem_sh     = {rem, quo[W-1]};
    trial      = rem_sh - {1'b0, dvs_mag};
    fits       = (rem_sh >= {1'b0, dvs_mag});
    quo_signed = neg ? -$signed(quo) : $signed(quo);
  end

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      done_r   <= 1'b0;
    end else begin
      done_r <= 1'b0;
      if (take) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        if (last_step) begin
          busy   <= 1'b0;
          done_r <= 1'b1;
        end else begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (take) begin
      // Work on magnitudes, sign goes back on at the end
      quo     <= i_req.dividend[W-1] ? W'(-i_req.dividend) : W'(i_req.dividend);
      dvs_mag <= i_req.divisor[W-1] ? -i_req.divisor : i_req.divisor;
      neg     <= i_req.dividend[W-1] ^ i_req.divisor[W-1];
      rem     <= '0;
    end else if (busy) begin
      if (last_step) begin
        quot_r <= quo_signed[`MAVG_SAMPLE_W-1:0];
      end else begin
        rem <= fits ? trial[W-1:0] : rem_sh[W-1:0];
        quo <= {quo[W-2:0], fits};
      end
    end
  end

  assign o_rsp = '{done: done_r, quotient: quot_r};

  a_start_when_idle: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    i_req.start |-> !busy)
    else $error("divider start while a division is running");

  // Scheduler timing relies on this latency
  a_fixed_latency: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    done_r |-> $past(i_req.start, `MAVG_DIV_CYCLES))
    else $error("divider done without a start %0d cycles earlier", `MAVG_DIV_CYCLES);

endmodule

`default_nettype wire

// ==== design/divide_sched.sv ====
//--------------------------------------------------------------------------
// Shares one divider between the I and Q sums, joins the quotients
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mavg_consts.svh"

module divide_sched
  import mavg_data_pkg::*;
(
  input  wire logic                   ce_clk,
  input  wire logic                   i_arst_n,
  input  wire logic                   i_isum_stb,
  input  wire sum_t                   i_isum,
  input  wire logic                   i_qsum_stb,
  input  wire sum_t                   i_qsum,
  input  wire logic [`MAVG_SUM_W-1:0] i_divisor,
  output div_req_t                    o_div_req,
  input  wire div_rsp_t               i_div_rsp,
  output logic                        o_out_stb,
  output iq_sample_t                  o_out_data
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_GRANT_I = 2'd1;
  localparam logic [1:0] ST_GRANT_Q = 2'd2;
  localparam logic [1:0] ST_EMIT    = 2'd3;

  logic [1:0]             state;
  logic                   start_r;
  sum_t                   dividend_r;
  logic [`MAVG_SUM_W-1:0] divisor_r;
  sum_t                   qsum_r;
  iq_sample_t             out_r;

  // ------------------------------------------------------------------------
  // Grant FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= ST_IDLE;
      start_r <= 1'b0;
    end else begin
      start_r <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_isum_stb) begin
            start_r <= 1'b1;
            state   <= ST_GRANT_I;
          end
        end
        ST_GRANT_I: begin
          if (i_div_rsp.done) begin
            start_r <= 1'b1;
            state   <= ST_GRANT_Q;
          end
        end
        ST_GRANT_Q: begin
          if (i_div_rsp.done) begin
            state <= ST_EMIT;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Operands and quotients
  always_ff @(posedge ce_clk) begin
    if (state == ST_IDLE) begin
      if (i_isum_stb) begin
        dividend_r <= i_isum;
        // Same divisor for both parts of one sample
        divisor_r  <= i_divisor;
      end
      if (i_qsum_stb) begin
        qsum_r <= i_qsum;
      end
    end
    if (state == ST_GRANT_I && i_div_rsp.done) begin
      out_r.i    <= i_div_rsp.quotient;
      dividend_r <= qsum_r;
    end
    if (state == ST_GRANT_Q && i_div_rsp.done) begin
      out_r.q <= i_div_rsp.quotient;
    end
  end

  assign o_div_req  = '{start: start_r, dividend: dividend_r, divisor: divisor_r};
  assign o_out_stb  = (state == ST_EMIT);
  assign o_out_data = out_r;

  // No back-pressure upstream, so a busy scheduler loses the sample
  a_sum_while_busy: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    (i_isum_stb || i_qsum_stb) |-> (state == ST_IDLE))
    else $error("sum strobe while divider is shared out, sample dropped");

endmodule

`default_nettype wire

// ==== design/moving_avg_top.sv ====
//--------------------------------------------------------------------------
// Moving average of complex samples: settings, two sums, shared divider
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mavg_consts.svh"

module moving_avg_top
  import mavg_cfg_pkg::*;
  import mavg_data_pkg::*;
(
  input  wire logic       ce_clk,
  input  wire logic       i_arst_n,
  input  wire set_bus_t   i_set,
  input  wire logic [7:0] i_rb_addr,
  output logic [31:0]     o_rb_data,
  input  wire logic       i_in_stb,
  input  wire iq_sample_t i_in_data,
  output logic            o_out_stb,
  output iq_sample_t      o_out_data
);

  logic [`MAVG_MAX_LEN_LOG2-1:0] sum_len;
  logic [`MAVG_SUM_W-1:0]        divisor;
  logic                          len_clear;
  logic                          isum_stb;
  logic                          qsum_stb;
  sum_t                          isum;
  sum_t                          qsum;
  div_req_t                      div_req;
  div_rsp_t                      div_rsp;

  mavg_settings u_settings (
    .ce_clk      (ce_clk),
    .i_arst_n    (i_arst_n),
    .i_set       (i_set),
    .i_rb_addr   (i_rb_addr),
    .o_rb_data   (o_rb_data),
    .o_sum_len   (sum_len),
    .o_divisor   (divisor),
    .o_len_clear (len_clear)
  );

  // I and Q parts are summed side by side
  moving_sum u_isum (
    .ce_clk   (ce_clk),
    .i_arst_n (i_arst_n),
    .i_clear  (len_clear),
    .i_len    (sum_len),
    .i_stb    (i_in_stb),
    .i_data   (i_in_data.i),
    .o_stb    (isum_stb),
    .o_sum    (isum)
  );

  moving_sum u_qsum (
    .ce_clk   (ce_clk),
    .i_arst_n (i_arst_n),
    .i_clear  (len_clear),
    .i_len    (sum_len),
    .i_stb    (i_in_stb),
    .i_data   (i_in_data.q),
    .o_stb    (qsum_stb),
    .o_sum    (qsum)
  );

  divide_sched u_sched (
    .ce_clk     (ce_clk),
    .i_arst_n   (i_arst_n),
    .i_isum_stb (isum_stb),
    .i_isum     (isum),
    .i_qsum_stb (qsum_stb),
    .i_qsum     (qsum),
    .i_divisor  (divisor),
    .o_div_req  (div_req),
    .i_div_rsp  (div_rsp),
    .o_out_stb  (o_out_stb),
    .o_out_data (o_out_data)
  );

  divide_int24 u_div (
    .ce_clk   (ce_clk),
    .i_arst_n (i_arst_n),
    .i_req    (div_req),
    .o_rsp    (div_rsp)
  );

endmodule

`default_nettype wire

// ==== test/tb_moving_avg_ref.svh ====
//--------------------------------------------------------------------------
// Reference model of the moving average: window history, window sum,
// truncating division and the xorshift generator
//--------------------------------------------------------------------------
`ifndef TB_MOVING_AVG_REF_SVH
`define TB_MOVING_AVG_REF_SVH

// Model settings, as last written
int m_len = 1;
int m_div = 1;

// Circular history of both parts, count since the last length write
int hist_i [0:255];
int hist_q [0:255];
int hist_cnt = 0;

function automatic void model_clear();
  hist_cnt = 0;
endfunction

function automatic void model_push(input int iv, input int qv);
  hist_i[hist_cnt % 256] = iv;
  hist_q[hist_cnt % 256] = qv;
  hist_cnt++;
endfunction

// Sum of the newest len values, or of all values since the clear
function automatic int window_sum(input bit q_part, input int len);
  int n;
  int acc;
  int idx;
  n   = (hist_cnt < len) ? hist_cnt : len;
  acc = 0;
  for (int k = 1; k <= n; k++) begin
    idx = (hist_cnt - k) % 256;
    acc += q_part ? hist_q[idx] : hist_i[idx];
  end
  return acc;
endfunction

// Integer division truncates toward zero, keep the low 16 bits
function automatic logic signed [15:0] trunc_q16(input int sum, input int div);
  int q;
  q = sum / div;
  return q[15:0];
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

`endif

// ==== test/tb_moving_avg.sv ====
//--------------------------------------------------------------------------
// Testbench for the moving average with clock, reset, settings and sample
// stimulus, output comparison, watchdog and final report
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mavg_consts.svh"

module tb_moving_avg
  import mavg_cfg_pkg::*;
  import mavg_data_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int LATENCY    = 56;
  localparam int N_PASS     = 6;
  localparam int N_WIN      = 12;
  localparam int N_REFILL   = 8;
  localparam int N_SIGN     = 6;
  localparam int N_WIDE     = 6;
  localparam int N_IQ       = 6;
  localparam int N_SAMPLES  = N_PASS + N_WIN + N_REFILL + N_SIGN + N_WIDE + N_IQ;
  localparam int WD_CYCLES  = N_SAMPLES * 64 + 200;

  logic       ce_clk;
  logic       i_arst_n;
  set_bus_t   i_set;
  logic [7:0] i_rb_addr;
  logic [31:0] o_rb_data;
  logic       i_in_stb;
  iq_sample_t i_in_data;
  logic       o_out_stb;
  iq_sample_t o_out_data;

  // Expected outputs in arrival order
  iq_sample_t exp_q [$];
  time        due_q [$];
  string      name_q [$];
  int         err_cnt = 0;
  int         chk_cnt = 0;
  logic [31:0] rng;

  `include "tb_moving_avg_ref.svh"

  moving_avg_top dut (
    .ce_clk     (ce_clk),
    .i_arst_n   (i_arst_n),
    .i_set      (i_set),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data),
    .i_in_stb   (i_in_stb),
    .i_in_data  (i_in_data),
    .o_out_stb  (o_out_stb),
    .o_out_data (o_out_data)
  );

  always #(CLK_PERIOD / 2) ce_clk = ~ce_clk;

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // --------------------------------------------------------------------------
  // Settings bus and readback
  // --------------------------------------------------------------------------
  task automatic set_len(input int len);
    set_bus_t w;
    w = '0;
    w.stb = 1'b1;
    w.addr = `MAVG_SR_SUM_LEN;
    w.data.len.sum_len = 8'(len);
    @(posedge ce_clk);
    i_set <= w;
    @(posedge ce_clk);
    i_set.stb <= 1'b0;
    m_len = len;
    // Every length write restarts the window
    model_clear();
  endtask

  task automatic set_div(input int div);
    set_bus_t w;
    w = '0;
    w.stb = 1'b1;
    w.addr = `MAVG_SR_DIVISOR;
    w.data.div.divisor = 24'(div);
    @(posedge ce_clk);
    i_set <= w;
    @(posedge ce_clk);
    i_set.stb <= 1'b0;
    m_div = div;
  endtask

  task automatic check_rb(input logic [7:0] addr, input logic [31:0] exp, input string name);
    @(posedge ce_clk);
    i_rb_addr <= addr;
    @(negedge ce_clk);
    chk_cnt++;
    assert (o_rb_data == exp) else begin
      err_cnt++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, o_rb_data);
    end
  endtask

  // One sample every 64 cycles with its expected value from the model
  task automatic send_sample(input int iv, input int qv, input string name);
    iq_sample_t s;
    iq_sample_t e;
    s.i = 16'(iv);
    s.q = 16'(qv);
    model_push(iv, qv);
    e.i = trunc_q16(window_sum(1'b0, m_len), m_div);
    e.q = trunc_q16(window_sum(1'b1, m_len), m_div);
    @(posedge ce_clk);
    i_in_stb  <= 1'b1;
    i_in_data <= s;
    exp_q.push_back(e);
    due_q.push_back($time + LATENCY * CLK_PERIOD + CLK_PERIOD / 2);
    name_q.push_back(name);
    @(posedge ce_clk);
    i_in_stb <= 1'b0;
    repeat (62) @(posedge ce_clk);
  endtask

  // --------------------------------------------------------------------------
  // Output comparison at the falling edge
  // --------------------------------------------------------------------------
  always @(negedge ce_clk) begin : compare_outputs
    iq_sample_t exp_d;
    time        due;
    string      nm;
    if (o_out_stb) begin
      assert (exp_q.size() > 0) else begin
        err_cnt++;
        $display("Output strobe at %0t with no input sample pending", $time);
      end
      if (exp_q.size() > 0) begin
        exp_d = exp_q.pop_front();
        due   = due_q.pop_front();
        nm    = name_q.pop_front();
        chk_cnt++;
        assert (o_out_data == exp_d) else begin
          err_cnt++;
          $display("[FAIL] %s: expected i=%0d q=%0d, actual i=%0d q=%0d",
                   nm, exp_d.i, exp_d.q, o_out_data.i, o_out_data.q);
        end
        assert ($time == due) else begin
          err_cnt++;
          $display("[FAIL] %s latency: expected output at %0t, actual %0t", nm, due, $time);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge ce_clk);
    $display("Timeout after %0d cycles, %0d expected outputs never arrived",
             WD_CYCLES, exp_q.size());
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main_seq
    logic [31:0] r;
    ce_clk    = 1'b0;
    i_arst_n  = 1'b0;
    i_set     = '0;
    i_rb_addr = '0;
    i_in_stb  = 1'b0;
    i_in_data = '0;
    rng       = 32'h4d7d;
    repeat (3) @(posedge ce_clk);
    i_arst_n <= 1'b1;

    check_rb(8'd0, 32'd1, "rb_reset_len");
    check_rb(8'd1, 32'd1, "rb_reset_div");
    check_rb(8'd7, 32'h0BADC0DE, "rb_filler");

    // Reset settings pass samples straight through
    for (int n = 0; n < N_PASS; n++) begin
      r = next_rand();
      send_sample(int'($signed(r[15:0])), int'($signed(r[31:16])), "passthru");
    end

    set_len(4);
    set_div(4);
    check_rb(8'd0, 32'd4, "rb_len");
    check_rb(8'd1, 32'd4, "rb_div");
    for (int n = 0; n < N_WIN; n++) begin
      r = next_rand();
      send_sample(int'($signed(r[15:0])), int'($signed(r[31:16])), "window4");
    end

    set_len(6);
    check_rb(8'd0, 32'd6, "rb_len_refill");
    for (int n = 0; n < N_REFILL; n++) begin
      r = next_rand();
      send_sample(int'($signed(r[15:0])), int'($signed(r[31:16])), "refill");
    end

    // Negative sums with a divisor that does not divide evenly
    set_len(3);
    set_div(3);
    for (int n = 0; n < N_SIGN; n++) begin
      r = next_rand();
      send_sample(-int'(r[11:0]) - 1, -int'(r[27:16]) - 1, "signs");
    end

    // Quotient wider than 16 bits
    set_len(8);
    set_div(1);
    for (int n = 0; n < N_WIDE; n++) begin
      r = next_rand();
      send_sample(30000 + int'(r[10:0]), -30000 - int'(r[26:16]), "wide");
    end

    set_len(2);
    set_div(2);
    for (int n = 0; n < N_IQ; n++) begin
      r = next_rand();
      if (n % 2 == 0) begin
        send_sample(int'(r[13:0]), -int'(r[29:16]) - 1, "iq_sign");
      end else begin
        send_sample(-int'(r[13:0]) - 1, int'(r[29:16]), "iq_sign");
      end
    end

    repeat (4) @(posedge ce_clk);
    assert (exp_q.size() == 0) else begin
      err_cnt++;
      $display("%0d expected outputs never arrived", exp_q.size());
    end

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
+incdir+test
design/mavg_cfg_pkg.sv
design/mavg_data_pkg.sv
design/mavg_settings.sv
design/moving_sum.sv
design/divide_int24.sv
design/divide_sched.sv
design/moving_avg_top.sv
test/tb_moving_avg.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the moving average testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_moving_avg -Mdir obj_dir

out=$(./obj_dir/Vtb_moving_avg || true)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
